// ==== logic/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] reg_t;
    typedef logic [31:0]     inst_t;
    typedef logic [11:0]     csr_addr_t;

    // machine csr addresses
    localparam csr_addr_t csr_mstatus = 12'h300;
    localparam csr_addr_t csr_mtvec   = 12'h305;
    localparam csr_addr_t csr_mepc    = 12'h341;
    localparam csr_addr_t csr_mcause  = 12'h342;

    localparam logic [6:0] opc_system = 7'b1110011;

    // full encodings, rs1/rd/funct3 all zero
    localparam inst_t inst_ecall  = 32'h0000_0073;
    localparam inst_t inst_ebreak = 32'h0010_0073;
    localparam inst_t inst_mret   = 32'h3020_0073;

    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;

    typedef struct packed {
        logic ecall;
        logic ebreak;
        logic mret;
    } dec_sys_t;

endpackage

`default_nettype wire

// ==== logic/trap_pkg.sv ====
`default_nettype none

package trap_pkg;

    import riscv_pkg::*;

    localparam reg_t cause_m_timer = 32'h8000_0007;
    localparam reg_t cause_m_ecall = 32'h0000_000B;
    localparam reg_t cause_break   = 32'h0000_0003;

    typedef enum logic [2:0] {
        idle        = 3'd0,
        wr_mepc     = 3'd1,
        wr_mepc_irq = 3'd2,
        wr_mstatus  = 3'd3,
        wr_mret     = 3'd4
    } trap_state_e;

    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        reg_t      data;
    } csr_wr_t;

    // sync for ecall/ebreak/mret, async for the timer
    typedef struct packed {
        logic sync;
        logic async;
    } flush_t;

    localparam reg_t pc_step  = 32'd4;
    localparam reg_t pc_step2 = 32'd8;

endpackage

`default_nettype wire

// ==== logic/sys_decode.sv ====
`default_nettype none

module sys_decode
    import riscv_pkg::*;
(
    input  inst_t    inst_i,
    input  logic     inst_valid_i,
    output dec_sys_t dec_o
);

    logic is_system;

    assign is_system = inst_valid_i && (inst_i[6:0] == opc_system);

    // other SYSTEM encodings (csr ops, wfi) leave everything low
    always_comb begin
        dec_o = '0;
        if (is_system) begin
            dec_o.ecall  = (inst_i == inst_ecall);
            dec_o.ebreak = (inst_i == inst_ebreak);
            dec_o.mret   = (inst_i == inst_mret);
        end
    end

endmodule

`default_nettype wire

// ==== logic/clint_timer.sv ====
`default_nettype none

module clint_timer
    import riscv_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic clint_we_i,
    input  reg_t clint_wdata_i,
    output reg_t mtime_o,
    output logic timer_irq_o
);

    reg_t mtime_q;
    reg_t mtimecmp_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // all ones keeps the interrupt quiet until software programs it
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp_q <= '1;
        end else if (clint_we_i) begin
            mtimecmp_q <= clint_wdata_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_irq_o <= 1'b0;
        end else begin
            timer_irq_o <= (mtime_q >= mtimecmp_q);
        end
    end

    assign mtime_o = mtime_q;

endmodule

`default_nettype wire

// ==== logic/csr_file.sv ====
`default_nettype none

module csr_file
    import riscv_pkg::*;
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  csr_wr_t   trap_wr_i,
    input  csr_wr_t   sw_wr_i,
    input  csr_addr_t raddr_i,
    output reg_t      rdata_o,
    output reg_t      mtvec_o,
    output reg_t      mepc_o,
    output reg_t      mstatus_o
);

    csr_wr_t wr;
    reg_t    mtvec_q;
    reg_t    mepc_q;
    reg_t    mstatus_q;
    reg_t    mcause_q;

    // trap sequencer has priority over software
    assign wr = trap_wr_i.we ? trap_wr_i : sw_wr_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtvec_q   <= 32'h0000_0100;
            mepc_q    <= '0;
            mstatus_q <= '0;
            mcause_q  <= '0;
        end else if (wr.we) begin
            case (wr.addr)
                csr_mtvec:   mtvec_q   <= wr.data;
                csr_mepc:    mepc_q    <= wr.data;
                csr_mstatus: mstatus_q <= wr.data;
                csr_mcause:  mcause_q  <= wr.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (raddr_i)
            csr_mtvec:   rdata_o = mtvec_q;
            csr_mepc:    rdata_o = mepc_q;
            csr_mstatus: rdata_o = mstatus_q;
            csr_mcause:  rdata_o = mcause_q;
            default:     rdata_o = '0;
        endcase
    end

    assign mtvec_o   = mtvec_q;
    assign mepc_o    = mepc_q;
    assign mstatus_o = mstatus_q;

endmodule

`default_nettype wire

// ==== logic/excp_ctrl.sv ====
`default_nettype none

module excp_ctrl
    import riscv_pkg::*;
    import trap_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     timer_irq_i,
    input  dec_sys_t dec_i,
    input  reg_t     pc_i,
    input  logic     id_jump_req_i,
    input  logic     ex_stall_i,
    input  logic     ls_stall_i,
    input  reg_t     mtvec_i,
    input  reg_t     mepc_i,
    input  reg_t     mstatus_i,
    output csr_wr_t  csr_wr_o,
    output logic     stall_o,
    output flush_t   flush_o,
    output logic     jump_req_o,
    output reg_t     jump_pc_o
);

    trap_state_e state_q, state_d;
    logic        any_stall, irq_en, trap_sync, ret_req;
    reg_t        pc_hold, pc_src, irq_pc;
    reg_t        cause_q;
    reg_t        mstatus_trap, mstatus_ret;
    csr_wr_t     wr_d;
    logic        csr_we_q;
    csr_addr_t   csr_addr_q;
    reg_t        csr_data_q;
    flush_t      flush_d;
    logic        jump_req_d;

    assign any_stall = ex_stall_i | ls_stall_i;
    assign irq_en    = timer_irq_i & mstatus_i[mstatus_mie];
    assign trap_sync = (dec_i.ecall | dec_i.ebreak) & ~any_stall;
    assign ret_req   = dec_i.mret & ~any_stall;

    // decode pc reads zero right after a jump
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_hold <= '0;
        end else if (id_jump_req_i) begin
            pc_hold <= pc_i;
        end
    end

    assign pc_src = (pc_i == '0) ? pc_hold : pc_i;

    always_comb begin
        if (ls_stall_i) begin
            irq_pc = pc_src - pc_step2;
        end else if (ex_stall_i) begin
            irq_pc = pc_src - pc_step;
        end else begin
            irq_pc = pc_src;
        end
    end

    always_comb begin
        mstatus_trap = mstatus_i;
        mstatus_trap[mstatus_mpie] = mstatus_i[mstatus_mie];
        mstatus_trap[mstatus_mie]  = 1'b0;
        mstatus_ret = mstatus_i;
        mstatus_ret[mstatus_mie]  = mstatus_i[mstatus_mpie];
        mstatus_ret[mstatus_mpie] = 1'b1;
    end

    always_comb begin
        state_d = idle;
        case (state_q)
            idle: begin
                if (irq_en) begin
                    state_d = any_stall ? wr_mepc : wr_mepc_irq;
                end else if (trap_sync) begin
                    state_d = wr_mepc;
                end else if (ret_req) begin
                    state_d = wr_mret;
                end
            end
            wr_mepc_irq: state_d = wr_mepc;
            wr_mepc:     state_d = wr_mstatus;
            default:     state_d = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == idle) begin
            if (irq_en) begin
                cause_q <= cause_m_timer;
            end else if (dec_i.ecall) begin
                cause_q <= cause_m_ecall;
            end else if (dec_i.ebreak) begin
                cause_q <= cause_break;
            end
        end
    end

    // csr write sequence, one write per cycle
    always_comb begin
        wr_d.we   = 1'b0;
        wr_d.addr = csr_addr_q;
        wr_d.data = csr_data_q;
        case (state_q)
            idle: begin
                if (irq_en) begin
                    wr_d = '{we: 1'b1, addr: csr_mepc, data: irq_pc};
                end else if (trap_sync) begin
                    wr_d = '{we: 1'b1, addr: csr_mepc, data: pc_i + pc_step};
                end else if (ret_req) begin
                    wr_d = '{we: 1'b1, addr: csr_mstatus, data: mstatus_ret};
                end
            end
            wr_mepc_irq: begin
                wr_d.we   = 1'b1;
                wr_d.addr = csr_mepc;
                if (ls_stall_i) begin
                    wr_d.data = pc_src - pc_step;
                end
            end
            wr_mepc: wr_d = '{we: 1'b1, addr: csr_mstatus, data: mstatus_trap};
            wr_mstatus: wr_d = '{we: 1'b1, addr: csr_mcause, data: cause_q};
            default: ;
        endcase
    end

    assign jump_req_d    = (state_q == idle) & (irq_en | trap_sync | ret_req);
    assign flush_d.async = (state_q == idle) & irq_en;
    assign flush_d.sync  = (state_q == idle) & ~irq_en & (trap_sync | ret_req);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            csr_we_q   <= 1'b0;
            flush_o    <= '0;
            jump_req_o <= 1'b0;
        end else begin
            csr_we_q   <= wr_d.we;
            flush_o    <= flush_d;
            jump_req_o <= jump_req_d;
        end
    end

    always_ff @(posedge clk) begin
        csr_addr_q <= wr_d.addr;
        csr_data_q <= wr_d.data;
        if (jump_req_d) begin
            // only mret returns through mepc
            jump_pc_o <= (irq_en | trap_sync) ? mtvec_i : mepc_i;
        end
    end

    assign csr_wr_o = '{we: csr_we_q, addr: csr_addr_q, data: csr_data_q};
    assign stall_o  = (state_d != idle);

endmodule

`default_nettype wire

// ==== logic/trap_subsys_top.sv ====
`default_nettype none

module trap_subsys_top
    import riscv_pkg::*;
    import trap_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  inst_t     inst_i,
    input  logic      inst_valid_i,
    input  reg_t      pc_i,
    input  logic      id_jump_req_i,
    input  logic      ex_stall_i,
    input  logic      ls_stall_i,
    input  logic      clint_we_i,
    input  reg_t      clint_wdata_i,
    input  csr_wr_t   csr_sw_i,
    input  csr_addr_t csr_raddr_i,
    output reg_t      csr_rdata_o,
    output reg_t      mtime_o,
    output logic      stall_o,
    output flush_t    flush_o,
    output logic      jump_req_o,
    output reg_t      jump_pc_o
);

    dec_sys_t dec;
    logic     timer_irq;
    reg_t     mtvec, mepc, mstatus;
    csr_wr_t  trap_wr;

    sys_decode u_sys_decode (
        .inst_i       (inst_i),
        .inst_valid_i (inst_valid_i),
        .dec_o        (dec)
    );

    clint_timer u_clint_timer (
        .clk           (clk),
        .rst_n         (rst_n),
        .clint_we_i    (clint_we_i),
        .clint_wdata_i (clint_wdata_i),
        .mtime_o       (mtime_o),
        .timer_irq_o   (timer_irq)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .trap_wr_i (trap_wr),
        .sw_wr_i   (csr_sw_i),
        .raddr_i   (csr_raddr_i),
        .rdata_o   (csr_rdata_o),
        .mtvec_o   (mtvec),
        .mepc_o    (mepc),
        .mstatus_o (mstatus)
    );

    excp_ctrl u_excp_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .timer_irq_i   (timer_irq),
        .dec_i         (dec),
        .pc_i          (pc_i),
        .id_jump_req_i (id_jump_req_i),
        .ex_stall_i    (ex_stall_i),
        .ls_stall_i    (ls_stall_i),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .mstatus_i     (mstatus),
        .csr_wr_o      (trap_wr),
        .stall_o       (stall_o),
        .flush_o       (flush_o),
        .jump_req_o    (jump_req_o),
        .jump_pc_o     (jump_pc_o)
    );

endmodule

`default_nettype wire

// ==== bench/trap_subsys_asserts.sv ====
`default_nettype none

module trap_subsys_asserts
    import trap_pkg::*;
(
    input logic        clk,
    input logic        rst_n,
    input logic        jump_req_o,
    input flush_t      flush_o,
    input logic        stall_o,
    input trap_state_e state_q
);

    timeunit 1ns;
    timeprecision 1ns;

    jump_single_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) jump_req_o |=> !jump_req_o
    ) else $error("jump_req_o held high for more than one cycle");

    flush_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(flush_o.sync && flush_o.async)
    ) else $error("sync and async flush raised together");

    // stall looks one state ahead
    stall_in_trap: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state_q != idle) |-> $past(stall_o)
    ) else $error("sequencer in a trap state without stall_o one cycle earlier");

    stall_leaves_idle: assert property (
        @(posedge clk) disable iff (!rst_n) stall_o |=> (state_q != idle)
    ) else $error("stall_o raised but the sequencer stayed idle");

endmodule

bind excp_ctrl trap_subsys_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .jump_req_o (jump_req_o),
    .flush_o    (flush_o),
    .stall_o    (stall_o),
    .state_q    (state_q)
);

`default_nettype wire

// ==== bench/trap_subsys_tb.sv ====
`default_nettype none

module trap_subsys_tb
    import riscv_pkg::*;
    import trap_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ns;

    // the tests take about 90 cycles
    localparam int   max_cycles = 400;
    localparam reg_t mtvec_val  = 32'h0000_0200;
    localparam reg_t mie_mask   = 32'h1 << mstatus_mie;
    localparam reg_t mpie_mask  = 32'h1 << mstatus_mpie;

    logic      clk;
    logic      rst_n;
    inst_t     inst;
    logic      inst_valid;
    reg_t      pc;
    logic      id_jump_req;
    logic      ex_stall;
    logic      ls_stall;
    logic      clint_we;
    reg_t      clint_wdata;
    csr_wr_t   csr_sw;
    csr_addr_t csr_raddr;
    reg_t      csr_rdata;
    reg_t      mtime;
    logic      stall;
    flush_t    flush;
    logic      jump_req;
    reg_t      jump_pc;

    int        err_cnt   = 0;
    int        test_cnt  = 0;
    int        fail_cnt  = 0;
    int        cycle_cnt = 0;
    reg_t      lcg_state = 32'hc0e4_651a;

    trap_subsys_top DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .inst_i        (inst),
        .inst_valid_i  (inst_valid),
        .pc_i          (pc),
        .id_jump_req_i (id_jump_req),
        .ex_stall_i    (ex_stall),
        .ls_stall_i    (ls_stall),
        .clint_we_i    (clint_we),
        .clint_wdata_i (clint_wdata),
        .csr_sw_i      (csr_sw),
        .csr_raddr_i   (csr_raddr),
        .csr_rdata_o   (csr_rdata),
        .mtime_o       (mtime),
        .stall_o       (stall),
        .flush_o       (flush),
        .jump_req_o    (jump_req),
        .jump_pc_o     (jump_pc)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic reg_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // word aligned and never zero
    function automatic reg_t rand_pc();
        reg_t v;
        v = lcg_next();
        return (v & 32'h000f_fffc) | 32'h0000_1000;
    endfunction

    task automatic check_val(input string name, input reg_t got, input reg_t exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        test_cnt++;
        if (err_cnt == err_before) begin
            $display("[%0t] %s: ok", $time, name);
        end else begin
            fail_cnt++;
            $display("[%0t] %s: %0d error(s)", $time, name, err_cnt - err_before);
        end
    endtask

    task automatic csr_write(input csr_addr_t addr, input reg_t data);
        @(posedge clk);
        csr_sw <= '{we: 1'b1, addr: addr, data: data};
        @(posedge clk);
        csr_sw <= '0;
    endtask

    task automatic csr_read(input csr_addr_t addr, output reg_t data);
        @(posedge clk);
        csr_raddr <= addr;
        @(negedge clk);
        data = csr_rdata;
    endtask

    // one-cycle instruction without back-pressure
    task automatic issue(input inst_t op, input reg_t at_pc);
        @(posedge clk);
        inst       <= op;
        inst_valid <= 1'b1;
        pc         <= at_pc;
        @(posedge clk);
        inst_valid <= 1'b0;
    endtask

    task automatic check_jump(input reg_t exp_pc, input logic exp_sync, input logic exp_async);
        check_bit("jump_req_o", jump_req, 1'b1);
        check_val("jump_pc_o", jump_pc, exp_pc);
        check_bit("flush_o.sync", flush.sync, exp_sync);
        check_bit("flush_o.async", flush.async, exp_async);
    endtask

    task automatic wait_jump(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!jump_req && n < limit) begin
            @(negedge clk);
            n++;
        end
        assert (jump_req) else begin
            $display("no jump_req_o within %0d cycles at %0t", limit, $time);
            err_cnt++;
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (stall && n < 20) begin
            @(negedge clk);
            n++;
        end
        assert (!stall) else begin
            $display("stall_o still high 20 cycles into the trap at %0t", $time);
            err_cnt++;
        end
        // csr writes land two edges after the sequencer lets go
        repeat (2) @(posedge clk);
    endtask

    task automatic test_sw_csr();
        int   e0;
        reg_t rd;
        e0 = err_cnt;
        csr_read(csr_mtvec, rd);
        check_val("mtvec after reset", rd, 32'h0000_0100);
        csr_write(csr_mtvec, mtvec_val);
        csr_write(csr_mstatus, mie_mask);
        csr_read(csr_mtvec, rd);
        check_val("mtvec", rd, mtvec_val);
        csr_read(csr_mstatus, rd);
        check_val("mstatus", rd, mie_mask);
        csr_read(12'h7c0, rd);
        check_val("unknown csr", rd, 32'h0);
        report_test("software csr access", e0);
    endtask

    task automatic test_ecall();
        int   e0;
        reg_t p, rd;
        e0 = err_cnt;
        p = rand_pc();
        issue(inst_ecall, p);
        @(negedge clk);
        check_jump(mtvec_val, 1'b1, 1'b0);
        check_bit("stall_o", stall, 1'b1);
        wait_idle();
        csr_read(csr_mepc, rd);
        check_val("mepc", rd, p + 32'd4);
        csr_read(csr_mcause, rd);
        check_val("mcause", rd, 32'h0000_000b);
        // MIE from the software test moves into MPIE
        csr_read(csr_mstatus, rd);
        check_val("mstatus", rd, mpie_mask);
        report_test("ecall", e0);
    endtask

    task automatic test_ebreak_stall();
        int   e0;
        reg_t p, old_cause, rd;
        e0 = err_cnt;
        p = rand_pc();
        csr_read(csr_mcause, old_cause);
        @(posedge clk);
        ex_stall   <= 1'b1;
        inst       <= inst_ebreak;
        inst_valid <= 1'b1;
        pc         <= p;
        repeat (4) begin
            @(negedge clk);
            assert (!jump_req && flush == '0) else begin
                $display("ebreak trapped while ex_stall_i was held at %0t", $time);
                err_cnt++;
            end
        end
        csr_read(csr_mcause, rd);
        check_val("mcause under stall", rd, old_cause);
        @(posedge clk);
        ex_stall <= 1'b0;
        @(posedge clk);
        inst_valid <= 1'b0;
        @(negedge clk);
        check_jump(mtvec_val, 1'b1, 1'b0);
        wait_idle();
        csr_read(csr_mcause, rd);
        check_val("mcause", rd, 32'h0000_0003);
        csr_read(csr_mepc, rd);
        check_val("mepc", rd, p + 32'd4);
        // MIE was already clear and MPIE takes it
        csr_read(csr_mstatus, rd);
        check_val("mstatus", rd, 32'h0);
        report_test("ebreak under stall", e0);
    endtask

    task automatic test_mret();
        int   e0;
        reg_t old_epc, rd;
        e0 = err_cnt;
        // MPIE set so the return turns interrupts back on
        csr_write(csr_mstatus, mpie_mask);
        csr_read(csr_mepc, old_epc);
        issue(inst_mret, rand_pc());
        @(negedge clk);
        check_jump(old_epc, 1'b1, 1'b0);
        wait_idle();
        csr_read(csr_mstatus, rd);
        check_val("mstatus", rd, mie_mask | mpie_mask);
        csr_read(csr_mepc, rd);
        check_val("mepc", rd, old_epc);
        report_test("mret", e0);
    endtask

    task automatic test_timer_irq();
        int   e0;
        reg_t p, t, rd;
        e0 = err_cnt;
        p = rand_pc();
        @(posedge clk);
        pc <= p;
        @(negedge clk);
        t = mtime;
        @(posedge clk);
        clint_we    <= 1'b1;
        clint_wdata <= t + 32'd5;
        @(posedge clk);
        clint_we <= 1'b0;
        // two edges since the sample
        @(negedge clk);
        check_val("mtime_o", mtime, t + 32'd2);
        wait_jump(20);
        check_jump(mtvec_val, 1'b0, 1'b1);
        wait_idle();
        csr_read(csr_mepc, rd);
        check_val("mepc", rd, p);
        csr_read(csr_mcause, rd);
        check_val("mcause", rd, 32'h8000_0007);
        csr_read(csr_mstatus, rd);
        check_bit("mstatus.MIE", rd[mstatus_mie], 1'b0);
        check_bit("mstatus.MPIE", rd[mstatus_mpie], 1'b1);
        // timer stays pending while MIE is clear
        repeat (8) begin
            @(negedge clk);
            assert (!jump_req) else begin
                $display("second interrupt taken with MIE clear at %0t", $time);
                err_cnt++;
            end
        end
        report_test("timer interrupt", e0);
    endtask

    task automatic test_irq_ls_stall();
        int   e0;
        reg_t p, old_st, rd;
        e0 = err_cnt;
        p = rand_pc();
        @(posedge clk);
        pc          <= p;
        id_jump_req <= 1'b1;
        @(posedge clk);
        id_jump_req <= 1'b0;
        pc          <= 32'h0;
        csr_read(csr_mstatus, old_st);
        // timer is still pending so setting MIE starts the trap
        csr_write(csr_mstatus, old_st | mie_mask);
        @(posedge clk);
        ls_stall <= 1'b1;
        @(negedge clk);
        check_jump(mtvec_val, 1'b0, 1'b1);
        wait_idle();
        @(posedge clk);
        ls_stall <= 1'b0;
        csr_read(csr_mepc, rd);
        check_val("mepc", rd, p - 32'd4);
        csr_read(csr_mcause, rd);
        check_val("mcause", rd, 32'h8000_0007);
        report_test("interrupt with ls_stall and zero pc", e0);
    endtask

    initial begin
        rst_n       = 1'b0;
        inst        = '0;
        inst_valid  = 1'b0;
        pc          = '0;
        id_jump_req = 1'b0;
        ex_stall    = 1'b0;
        ls_stall    = 1'b0;
        clint_we    = 1'b0;
        clint_wdata = '0;
        csr_sw      = '0;
        csr_raddr   = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        test_sw_csr();
        test_ecall();
        test_ebreak_stall();
        test_mret();
        test_timer_irq();
        test_irq_ls_stall();

        $display("%0d tests, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== trap_subsys.f ====
logic/riscv_pkg.sv
logic/trap_pkg.sv
logic/sys_decode.sv
logic/clint_timer.sv
logic/csr_file.sv
logic/excp_ctrl.sv
logic/trap_subsys_top.sv
bench/trap_subsys_asserts.sv
bench/trap_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= trap_subsys_tb
FLIST     ?= trap_subsys.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee /dev/stderr | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)
